// ==== Makefile ====
TOP = rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== bench/rv_core_sva.sv ====
`default_nettype none

module rv_core_sva import rv_pkg::*; (
  input wire logic            clk,
  input wire logic            rst,
  input wire logic [xlen-1:0] current_pc,
  input wire logic [xlen-1:0] next_pc,
  input wire logic            retire_valid,
  input wire logic            halted,
  input wire logic            trap
);

  timeunit 1ns;
  timeprecision 1ps;

  // a running core steps by one word or stops at that edge
  a_pc_steps: assert property (@(posedge clk) disable iff (rst)
    (!halted && !trap) |=> halted || trap || current_pc == $past(current_pc) + xlen'(4))
    else $error("current_pc did not step by 4 while running");

  // stopped core holds its pc and retires nothing
  a_stopped_frozen: assert property (@(posedge clk) disable iff (rst)
    (halted || trap) |-> (next_pc == current_pc) && !retire_valid)
    else $error("stopped core still advancing or retiring");

  // both stop states are exclusive
  a_status_onehot: assert property (@(posedge clk) disable iff (rst)
    !(halted && trap))
    else $error("halted and trap high together");

  // stop states are sticky until reset
  a_halted_sticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted)
    else $error("halted dropped without reset");

  a_trap_sticky: assert property (@(posedge clk) disable iff (rst)
    trap |=> trap)
    else $error("trap dropped without reset");

endmodule

bind rv_core rv_core_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .current_pc   (current_pc),
  .next_pc      (next_pc),
  .retire_valid (retire.valid),
  .halted       (halted),
  .trap         (trap)
);

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_runs      = 4;
  localparam int insts_per_run = 64;
  localparam int final_phase   = 16;
  localparam int reset_cycles  = 2;
  // one cycle per instruction, reset and slack per run, plus margin
  localparam int cycle_limit   = num_runs * (insts_per_run + reset_cycles + 4) + 50;
  localparam logic [inst_width-1:0] nop_word = 32'h0000_0013;

  typedef enum logic [2:0] {
    cls_addi, cls_add, cls_sub, cls_lui, cls_auipc, cls_ebreak, cls_illegal
  } inst_class_e;

  logic                  clk;
  logic                  rst;
  logic [inst_width-1:0] inst;
  logic [xlen-1:0]       current_pc;
  logic [xlen-1:0]       next_pc;
  retire_t               retire;
  logic                  halted;
  logic                  trap;

  // reference model state
  logic [31:0]     lfsr;
  logic [xlen-1:0] model_regs [num_regs];
  logic [xlen-1:0] model_pc;
  core_state_e     model_state;
  int              cycle_count;

  rv_core UUT (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .retire     (retire),
    .halted     (halted),
    .trap       (trap)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: %0d cycles passed and the tests did not finish", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "cycle limit reached");
    end
  end

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit, msb first
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic [xlen-1:0] sext_i(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [xlen-1:0] upper_imm(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'h000};
  endfunction

  // x0 reads as zero in the model too
  function automatic logic [xlen-1:0] model_read(input logic [4:0] idx);
    return (idx == 5'd0) ? '0 : model_regs[idx];
  endfunction

  // rv64 encodings straight from the isa field layout
  function automatic logic [31:0] encode(input inst_class_e cls, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [19:0] imm, input logic [1:0] ill);
    case (cls)
      cls_addi:  return {imm[11:0], rs1, 3'b000, rd, 7'b001_0011};
      cls_add:   return {7'b000_0000, rs2, rs1, 3'b000, rd, 7'b011_0011};
      cls_sub:   return {7'b010_0000, rs2, rs1, 3'b000, rd, 7'b011_0011};
      cls_lui:   return {imm, rd, 7'b011_0111};
      cls_auipc: return {imm, rd, 7'b001_0111};
      cls_ebreak: return 32'h0010_0073;
      default: begin
        // zero word, slli, ecall, mul
        case (ill)
          2'd0:    return 32'h0000_0000;
          2'd1:    return {12'h001, rs1, 3'b001, rd, 7'b001_0011};
          2'd2:    return 32'h0000_0073;
          default: return {7'b000_0001, rs2, rs1, 3'b000, rd, 7'b011_0011};
        endcase
      end
    endcase
  endfunction

  // mostly full range, sometimes x0..x7 to hit x0 and reuse
  task automatic pick_reg(output logic [4:0] idx);
    logic [31:0] r;
    take_bits(2, r);
    if (r[1:0] == 2'd0) begin
      take_bits(3, r);
    end else begin
      take_bits(5, r);
    end
    idx = r[4:0];
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst  = 1'b1;
    inst = nop_word;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    model_pc    = reset_vector;
    model_state = st_run;
    // out of reset, nop still on the bus
    check_value("current_pc", current_pc, reset_vector);
    check_value("halted", xlen'(halted), '0);
    check_value("trap", xlen'(trap), '0);
    check_value("retire.valid", xlen'(retire.valid), xlen'(1));
  endtask

  // called at a falling edge, returns at the next one
  task automatic step_one(input bit stop_phase, input bit force_stop, input bit want_trap);
    inst_class_e     cls;
    logic [31:0]     r;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [19:0]     imm;
    logic [1:0]      ill;
    logic [xlen-1:0] exp_wdata;
    logic [xlen-1:0] exp_next;
    logic            exp_valid;
    logic            writes;

    // state after the last edge
    check_value("current_pc", current_pc, model_pc);
    check_value("halted", xlen'(halted), xlen'(model_state == st_halted));
    check_value("trap", xlen'(trap), xlen'(model_state == st_trapped));

    take_bits(3, r);
    case (r[2:0])
      3'd0, 3'd1: cls = cls_addi;
      3'd2:       cls = cls_add;
      3'd3, 3'd4: cls = cls_sub;
      3'd5:       cls = cls_lui;
      default:    cls = cls_auipc;
    endcase
    // stop injection only late in a run, kind fixed by run parity
    if (stop_phase) begin
      take_bits(2, r);
      if (r[1:0] == 2'd0 || force_stop) begin
        cls = want_trap ? cls_illegal : cls_ebreak;
      end
    end
    pick_reg(rd);
    pick_reg(rs1);
    pick_reg(rs2);
    take_bits(20, r);
    imm = r[19:0];
    take_bits(2, r);
    ill = r[1:0];

    inst = encode(cls, rd, rs1, rs2, imm, ill);
    #10;

    case (cls)
      cls_addi:  exp_wdata = model_read(rs1) + sext_i(imm[11:0]);
      cls_add:   exp_wdata = model_read(rs1) + model_read(rs2);
      cls_sub:   exp_wdata = model_read(rs1) - model_read(rs2);
      cls_lui:   exp_wdata = upper_imm(imm);
      cls_auipc: exp_wdata = model_pc + upper_imm(imm);
      default:   exp_wdata = '0;
    endcase
    writes = (cls != cls_ebreak) && (cls != cls_illegal);

    if (model_state == st_run && cls != cls_illegal) begin
      exp_valid = 1'b1;
      exp_next  = (cls == cls_ebreak) ? model_pc : model_pc + xlen'(4);
    end else begin
      exp_valid = 1'b0;
      exp_next  = model_pc;
    end

    check_value("next_pc", next_pc, exp_next);
    check_value("retire.valid", xlen'(retire.valid), xlen'(exp_valid));
    if (exp_valid) begin
      check_value("retire.pc", retire.pc, model_pc);
    end
    if (exp_valid && writes) begin
      check_value("retire.rd", xlen'(retire.rd), xlen'(rd));
      check_value("retire.wdata", retire.wdata, exp_wdata);
    end

    // model moves as the dut will at the rising edge
    if (model_state == st_run) begin
      if (writes && rd != 5'd0) begin
        model_regs[rd] = exp_wdata;
      end
      if (cls == cls_ebreak) begin
        model_state = st_halted;
      end else if (cls == cls_illegal) begin
        model_state = st_trapped;
      end
    end
    model_pc = exp_next;

    @(negedge clk);
  endtask

  initial begin
    rst         = 1'b1;
    inst        = nop_word;
    lfsr        = 32'hcdbf;
    cycle_count = 0;
    model_pc    = reset_vector;
    model_state = st_run;

    for (int run = 0; run < num_runs; run++) begin
      apply_reset();
      for (int n = 0; n < insts_per_run; n++) begin
        step_one(n >= insts_per_run - final_phase, n == insts_per_run - 1, run[0]);
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // datapath widths
  localparam int xlen         = 64;
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;
  localparam int num_regs     = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_vector = 64'h0000_0000_8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opcode_op_imm = 7'b001_0011;
  localparam logic [6:0] opcode_op     = 7'b011_0011;
  localparam logic [6:0] opcode_lui    = 7'b011_0111;
  localparam logic [6:0] opcode_auipc  = 7'b001_0111;
  localparam logic [6:0] opcode_system = 7'b111_0011;

  // add/sub share funct3, split by funct7
  localparam logic [2:0] funct3_add = 3'b000;
  localparam logic [6:0] funct7_add = 7'b000_0000;
  localparam logic [6:0] funct7_sub = 7'b010_0000;

  // ebreak is matched as a whole word
  localparam logic [inst_width-1:0] ebreak_word = 32'h0010_0073;

  typedef enum logic [1:0] {
    alu_add    = 2'd0,
    alu_sub    = 2'd1,
    alu_pass_b = 2'd2
  } alu_op_e;

  // first alu operand source
  typedef enum logic {
    opa_rs1 = 1'b0,
    opa_pc  = 1'b1
  } opa_sel_e;

  typedef enum logic [1:0] {
    st_run     = 2'd0,
    st_halted  = 2'd1,
    st_trapped = 2'd2
  } core_state_e;

  // decoder output, one instruction's worth of control
  typedef struct packed {
    logic [reg_id_width-1:0] rd;
    logic [reg_id_width-1:0] rs1;
    logic [reg_id_width-1:0] rs2;
    logic [xlen-1:0]         imm;
    logic                    use_imm;
    opa_sel_e                opa_sel;
    alu_op_e                 alu_op;
    logic                    writes_rd;
    logic                    is_ebreak;
    logic                    illegal;
  } decoded_t;

  // per-cycle retire record for an outside checker
  typedef struct packed {
    logic                    valid;
    logic [xlen-1:0]         pc;
    logic [reg_id_width-1:0] rd;
    logic [xlen-1:0]         wdata;
  } retire_t;

endpackage

`default_nettype wire

// ==== flist.f ====
common/rv_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/pc_unit.sv
hw/rv_core.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv

// ==== hw/alu.sv ====
`default_nettype none

module alu import rv_pkg::*; (
  input  decoded_t              dec,
  input  wire logic [xlen-1:0]  pc,
  input  wire logic [xlen-1:0]  rdata_1,
  input  wire logic [xlen-1:0]  rdata_2,
  output logic      [xlen-1:0]  result
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  // operand a: pc for auipc, rs1 otherwise
  assign op_a = (dec.opa_sel == opa_pc) ? pc : rdata_1;

  // operand b: immediate or rs2
  assign op_b = dec.use_imm ? dec.imm : rdata_2;

  // all arithmetic wraps at 64 bits
  always_comb begin
    case (dec.alu_op)
      alu_add: begin
        result = op_a + op_b;
      end
      alu_sub: begin
        result = op_a - op_b;
      end
      alu_pass_b: begin
        // lui path
        result = op_b;
      end
      default: begin
        result = op_b;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`default_nettype none

module decoder import rv_pkg::*; (
  input  wire logic [inst_width-1:0] inst,
  output decoded_t                   dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;

  // fixed field positions
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // I-type, sign from bit 31
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  // U-type, upper 20 bits then sign-extended past bit 31
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};

  always_comb begin
    // register indices are always taken from their slots
    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.imm = imm_i;

    // default is an illegal encoding with no side effects
    dec.use_imm   = 1'b0;
    dec.opa_sel   = opa_rs1;
    dec.alu_op    = alu_add;
    dec.writes_rd = 1'b0;
    dec.is_ebreak = 1'b0;
    dec.illegal   = 1'b1;

    case (opcode)
      opcode_op_imm: begin
        // addi only
        if (funct3 == funct3_add) begin
          dec.use_imm   = 1'b1;
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      opcode_op: begin
        if (funct3 == funct3_add && funct7 == funct7_add) begin
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end else if (funct3 == funct3_add && funct7 == funct7_sub) begin
          dec.alu_op    = alu_sub;
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      opcode_lui: begin
        // immediate straight through
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = alu_pass_b;
        dec.writes_rd = 1'b1;
        dec.illegal   = 1'b0;
      end
      opcode_auipc: begin
        // pc plus upper immediate
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.opa_sel   = opa_pc;
        dec.writes_rd = 1'b1;
        dec.illegal   = 1'b0;
      end
      opcode_system: begin
        // only the exact ebreak word, ecall and csr ops trap
        if (inst == ebreak_word) begin
          dec.is_ebreak = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`default_nettype none

module pc_unit import rv_pkg::*; (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            is_ebreak,
  input  wire logic            illegal,
  output logic      [xlen-1:0] current_pc,
  output logic      [xlen-1:0] next_pc,
  output logic                 commit,
  output core_state_e          state
);

  // the only place the run condition is tested
  assign commit = (state == st_run) && !illegal;

  // ebreak commits but does not advance
  assign next_pc = (commit && !is_ebreak) ? current_pc + xlen'(4) : current_pc;

  // pc register
  always_ff @(posedge clk) begin
    if (rst) begin
      current_pc <= reset_vector;
    end else begin
      current_pc <= next_pc;
    end
  end

  // run / halted / trapped
  // halted and trapped are sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_run;
    end else begin
      case (state)
        st_run: begin
          if (illegal) begin
            state <= st_trapped;
          end else if (is_ebreak) begin
            state <= st_halted;
          end
        end
        st_halted: begin
          state <= st_halted;
        end
        st_trapped: begin
          state <= st_trapped;
        end
        default: begin
          // unused encoding, treat as a trap
          state <= st_trapped;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none

module regfile import rv_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic [reg_id_width-1:0] rs1,
  input  wire logic [reg_id_width-1:0] rs2,
  input  wire logic [reg_id_width-1:0] rd,
  input  wire logic                    wen,
  input  wire logic [xlen-1:0]         wdata,
  output logic      [xlen-1:0]         rdata_1,
  output logic      [xlen-1:0]         rdata_2
);

  logic [xlen-1:0] regs [num_regs];

  // write at the edge, x0 never stored
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // asynchronous read ports
  // x0 forced to zero on read as well
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [inst_width-1:0] inst,
  output logic      [xlen-1:0]       current_pc,
  output logic      [xlen-1:0]       next_pc,
  output retire_t                    retire,
  output logic                       halted,
  output logic                       trap
);

  decoded_t        dec;
  logic [xlen-1:0] rdata_1;
  logic [xlen-1:0] rdata_2;
  logic [xlen-1:0] result;
  logic            commit;
  core_state_e     state;

  // inst is the word at current_pc, fetched outside
  decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  // write lands at the end of the same cycle
  regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rd      (dec.rd),
    .wen     (dec.writes_rd & commit),
    .wdata   (result),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // operand muxing lives in the alu
  alu u_alu (
    .dec     (dec),
    .pc      (current_pc),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .result  (result)
  );

  pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .is_ebreak  (dec.is_ebreak),
    .illegal    (dec.illegal),
    .current_pc (current_pc),
    .next_pc    (next_pc),
    .commit     (commit),
    .state      (state)
  );

  // retire record
  // valid on the ebreak cycle too, with rd write suppressed in the decoder
  assign retire.valid = commit;
  assign retire.pc    = current_pc;
  assign retire.rd    = dec.rd;
  assign retire.wdata = result;

  // status decodes
  assign halted = (state == st_halted);
  assign trap   = (state == st_trapped);

endmodule

`default_nettype wire
